// File: source/kbd_pkg.sv
//////////////////////////////
// keyboard package
// code widths, key event and
// receiver state shared by the
// ps/2 to lisp machine path
//////////////////////////////
`default_nettype none

package kbd_pkg;

  // one data byte of a ps/2 frame
  typedef logic [7:0] ps2_byte_t;

  // bit 8 set for keys sent behind an E0 prefix
  typedef logic [8:0] raw_code_t;

  // lisp machine key code, zero when unmapped
  typedef logic [7:0] lm_code_t;

  // released is set on key up
  typedef struct packed {
    logic     released;
    lm_code_t code;
  } key_event_t;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } rx_state_t;

  // prefix bytes from the keyboard
  localparam ps2_byte_t PS2_PREFIX_EXT = 8'hE0;
  localparam ps2_byte_t PS2_PREFIX_REL = 8'hF0;

endpackage

`default_nettype wire

// File: source/ps2_rx.sv
//////////////////////////////
// ps/2 receiver
// samples clock and data, shifts
// in 11-bit frames and checks them
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module ps2_rx import kbd_pkg::*; #(
  parameter int IDLE_TIMEOUT = 2000
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      ps2_clk,
  input  logic      ps2_data,
  output ps2_byte_t rx_byte,
  output logic      rx_valid,
  output logic      frame_error
);

  localparam int CNT_W = $clog2(IDLE_TIMEOUT + 1);

  logic [1:0]       clk_sync;
  logic [1:0]       data_sync;
  logic             clk_prev;
  logic             clk_fall;
  rx_state_t        state;
  logic [3:0]       bit_cnt;
  logic [10:0]      shift_reg;
  logic [CNT_W-1:0] idle_cnt;
  logic             frame_ok;

  // two-flop synchronizers, lines idle high
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign clk_fall = clk_prev & ~clk_sync[1];

  // bit counter and idle timeout
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      bit_cnt  <= '0;
      idle_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          bit_cnt  <= '0;
          idle_cnt <= '0;
          if (clk_fall) begin
            state   <= SHIFT;
            bit_cnt <= 4'd1;
          end
        end
        SHIFT: begin
          if (clk_fall) begin
            idle_cnt <= '0;
            bit_cnt  <= bit_cnt + 4'd1;
            // eleventh bit is the stop bit
            if (bit_cnt == 4'd10) begin
              state <= DONE;
            end
          end else if (idle_cnt == CNT_W'(IDLE_TIMEOUT - 1)) begin
            // keyboard went quiet mid frame
            state <= IDLE;
          end else begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // lsb first, so the start bit ends up in bit 0
  always_ff @(posedge clk) begin
    if (clk_fall && state != DONE) begin
      shift_reg <= {data_sync[1], shift_reg[10:1]};
    end
  end

  // start low, odd parity over data and parity, stop high
  assign frame_ok = ~shift_reg[0] & (^shift_reg[9:1]) & shift_reg[10];

  assign rx_byte     = shift_reg[8:1];
  assign rx_valid    = (state == DONE) & frame_ok;
  assign frame_error = (state == DONE) & ~frame_ok;

endmodule

`default_nettype wire

// File: source/scancode_rom.sv
//////////////////////////////
// scancode rom
// raw ps/2 codes to lisp
// machine key codes
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module scancode_rom import kbd_pkg::*; (
  input  raw_code_t addr,
  output lm_code_t  data
);

  // lisp machine function keys
  localparam lm_code_t LM_K_BREAK        = 8'o201;
  localparam lm_code_t LM_K_CLEAR_INPUT  = 8'o202;
  localparam lm_code_t LM_K_CALL         = 8'o203;
  localparam lm_code_t LM_K_TERMINAL     = 8'o204;
  localparam lm_code_t LM_K_HELP         = 8'o206;
  localparam lm_code_t LM_K_RUBOUT       = 8'o207;
  localparam lm_code_t LM_K_OVERSTRIKE   = 8'o210;
  localparam lm_code_t LM_K_TAB          = 8'o211;
  localparam lm_code_t LM_K_CLEAR_SCREEN = 8'o214;
  localparam lm_code_t LM_K_RETURN       = 8'o215;
  localparam lm_code_t LM_K_ABORT        = 8'o221;
  localparam lm_code_t LM_K_RESUME       = 8'o222;
  localparam lm_code_t LM_K_END          = 8'o224;
  localparam lm_code_t LM_K_HAND_UP      = 8'o231;
  localparam lm_code_t LM_K_HAND_DOWN    = 8'o232;
  localparam lm_code_t LM_K_HAND_LEFT    = 8'o233;
  localparam lm_code_t LM_K_HAND_RIGHT   = 8'o234;
  localparam lm_code_t LM_K_SYSTEM       = 8'o235;
  localparam lm_code_t LM_K_NETWORK      = 8'o236;

  // modifier keys
  localparam lm_code_t LM_SH_LEFT_SHIFT    = 8'o024;
  localparam lm_code_t LM_SH_LEFT_TOP      = 8'o104;
  localparam lm_code_t LM_SH_LEFT_CONTROL  = 8'o020;
  localparam lm_code_t LM_SH_LEFT_META     = 8'o045;
  localparam lm_code_t LM_SH_RIGHT_SHIFT   = 8'o025;
  localparam lm_code_t LM_SH_RIGHT_TOP     = 8'o155;
  localparam lm_code_t LM_SH_RIGHT_CONTROL = 8'o026;
  localparam lm_code_t LM_SH_RIGHT_META    = 8'o165;
  localparam lm_code_t LM_SH_CAPSLOCK      = 8'o125;

  always_comb begin
    case (addr)
      // shift, gui keys as top, ctrl, alt as meta, caps lock
      9'h012: data = LM_SH_LEFT_SHIFT;
      9'h059: data = LM_SH_RIGHT_SHIFT;
      9'h11f: data = LM_SH_LEFT_TOP;
      9'h127: data = LM_SH_RIGHT_TOP;
      9'h014: data = LM_SH_LEFT_CONTROL;
      9'h114: data = LM_SH_RIGHT_CONTROL;
      9'h011: data = LM_SH_LEFT_META;
      9'h111: data = LM_SH_RIGHT_META;
      9'h058: data = LM_SH_CAPSLOCK;

      // f1 to f7, then f12
      9'h005: data = LM_K_TERMINAL;
      9'h006: data = LM_K_SYSTEM;
      9'h004: data = LM_K_NETWORK;
      9'h00c: data = LM_K_ABORT;
      9'h003: data = LM_K_CLEAR_INPUT;
      9'h00b: data = LM_K_HELP;
      9'h083: data = LM_K_CLEAR_SCREEN;
      9'h007: data = LM_K_BREAK;

      // navigation block
      9'h16c: data = LM_K_CALL;
      9'h169: data = LM_K_END;
      9'h17d: data = LM_K_BREAK;
      9'h17a: data = LM_K_RESUME;
      9'h170: data = LM_K_ABORT;
      9'h171: data = LM_K_OVERSTRIKE;

      // esc and cursor arrows
      9'h076: data = LM_K_TERMINAL;
      9'h175: data = LM_K_HAND_UP;
      9'h172: data = LM_K_HAND_DOWN;
      9'h16b: data = LM_K_HAND_LEFT;
      9'h174: data = LM_K_HAND_RIGHT;

      9'h066: data = LM_K_RUBOUT;
      9'h05a: data = LM_K_RETURN;
      9'h00d: data = LM_K_TAB;

      // letters a to z
      9'h01c: data = 8'o123;
      9'h032: data = 8'o114;
      9'h021: data = 8'o164;
      9'h023: data = 8'o163;
      9'h024: data = 8'o162;
      9'h02b: data = 8'o013;
      9'h034: data = 8'o113;
      9'h033: data = 8'o053;
      9'h043: data = 8'o032;
      9'h03b: data = 8'o153;
      9'h042: data = 8'o033;
      9'h04b: data = 8'o073;
      9'h03a: data = 8'o154;
      9'h031: data = 8'o054;
      9'h044: data = 8'o072;
      9'h04d: data = 8'o172;
      9'h015: data = 8'o122;
      9'h02d: data = 8'o012;
      9'h01b: data = 8'o063;
      9'h02c: data = 8'o112;
      9'h03c: data = 8'o152;
      9'h02a: data = 8'o014;
      9'h01d: data = 8'o062;
      9'h022: data = 8'o064;
      9'h035: data = 8'o052;
      9'h01a: data = 8'o124;

      // digits 0 to 9
      9'h045: data = 8'o171;
      9'h016: data = 8'o121;
      9'h01e: data = 8'o061;
      9'h026: data = 8'o161;
      9'h025: data = 8'o011;
      9'h02e: data = 8'o111;
      9'h036: data = 8'o051;
      9'h03d: data = 8'o151;
      9'h03e: data = 8'o031;
      9'h046: data = 8'o071;

      // punctuation
      9'h00e: data = 8'o077;  // backquote
      9'h04e: data = 8'o131;
      9'h055: data = 8'o126;
      9'h05d: data = 8'o037;  // backslash
      9'h054: data = 8'o132;
      9'h05b: data = 8'o137;
      9'h04c: data = 8'o173;
      9'h052: data = 8'o133;
      9'h041: data = 8'o034;
      9'h049: data = 8'o074;
      9'h04a: data = 8'o174;

      // anything else has no lisp machine key
      default: data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/scancode_decoder.sv
//////////////////////////////
// scancode decoder
// prefix tracking, rom lookup
// and key event strobe
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module scancode_decoder import kbd_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  ps2_byte_t  rx_byte,
  input  logic       rx_valid,
  output logic       push,
  output key_event_t key_event
);

  raw_code_t raw_code;
  lm_code_t  lm_code;
  logic      ext;
  logic      rel;
  logic      is_prefix;

  assign is_prefix = (rx_byte == PS2_PREFIX_EXT) || (rx_byte == PS2_PREFIX_REL);

  // extended keys live in the upper half of the table
  assign raw_code = {ext, rx_byte};

  scancode_rom u_rom (
    .addr (raw_code),
    .data (lm_code)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ext  <= 1'b0;
      rel  <= 1'b0;
      push <= 1'b0;
    end else begin
      push <= rx_valid && !is_prefix && (lm_code != '0);
      if (rx_valid) begin
        if (rx_byte == PS2_PREFIX_EXT) begin
          ext <= 1'b1;
        end else if (rx_byte == PS2_PREFIX_REL) begin
          rel <= 1'b1;
        end else begin
          // code byte ends the sequence, mapped or not
          ext <= 1'b0;
          rel <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && !is_prefix) begin
      key_event.released <= rel;
      key_event.code     <= lm_code;
    end
  end

endmodule

`default_nettype wire

// File: source/key_fifo.sv
//////////////////////////////
// key event fifo
// circular queue read by strobe,
// drops pushes while full
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module key_fifo import kbd_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push,
  input  key_event_t key_event,
  input  logic       rd,
  output key_event_t key,
  output logic       empty,
  output logic       overflow
);

  localparam int AW = $clog2(FIFO_DEPTH);

  key_event_t  mem [FIFO_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_write;
  logic        do_read;

  // top pointer bit tells a full ring from an empty one
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_write = push & ~full;
  assign do_read  = rd & ~empty;
  assign overflow = push & full;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr[AW-1:0]] <= key_event;
    end
  end

  // head of queue, valid while not empty
  assign key = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// File: source/ps2_lispm_kbd.sv
//////////////////////////////
// ps/2 to lisp machine keyboard
// receiver, decoder and event
// queue for the host
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module ps2_lispm_kbd import kbd_pkg::*; #(
  parameter int IDLE_TIMEOUT = 2000,
  parameter int FIFO_DEPTH   = 8
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  input  logic       rd,
  output key_event_t key,
  output logic       empty,
  output logic       overflow,
  output logic       frame_error
);

  ps2_byte_t  rx_byte;
  logic       rx_valid;
  logic       push;
  key_event_t key_event;

  ps2_rx #(
    .IDLE_TIMEOUT (IDLE_TIMEOUT)
  ) u_rx (
    .clk         (clk),
    .arst_n      (arst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_error (frame_error)
  );

  scancode_decoder u_decoder (
    .clk       (clk),
    .arst_n    (arst_n),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .push      (push),
    .key_event (key_event)
  );

  // host side queue
  key_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .key_event (key_event),
    .rd        (rd),
    .key       (key),
    .empty     (empty),
    .overflow  (overflow)
  );

endmodule

`default_nettype wire

// File: verification/kbd_checker.sv
//////////////////////////////
// keyboard checker
// bound assertions on strobes
// and host side outputs
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module kbd_checker #(
  parameter int FIFO_DEPTH = 8
) (
  input wire logic clk,
  input wire logic arst_n,
  input wire logic ps2_clk,
  input wire logic rx_valid,
  input wire logic frame_error,
  input wire logic push,
  input wire logic rd,
  input wire logic overflow,
  input wire logic empty
);

  int   fail_cnt = 0;
  int   level;
  logic push_seen;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_seen <= 1'b0;
    end else if (push) begin
      push_seen <= 1'b1;
    end
  end

  // event count rebuilt from the strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      level <= 0;
    end else begin
      level <= level + int'(push && level < FIFO_DEPTH) - int'(rd && level > 0);
    end
  end

  // queue stays empty until the first event arrives
  empty_before_push: assert property (@(posedge clk) disable iff (!arst_n)
    !push_seen |-> empty)
    else begin
      fail_cnt++;
      $error("empty went low before any push");
    end

  overflow_when_full: assert property (@(posedge clk) disable iff (!arst_n)
    overflow == (push && level == FIFO_DEPTH))
    else begin
      fail_cnt++;
      $error("overflow does not match a push into a full queue");
    end

  // strobes come three cycles after the ps/2 clock falls at the pins
  strobe_after_clk_fall: assert property (@(posedge clk) disable iff (!arst_n)
    (rx_valid || frame_error) |-> ($past(ps2_clk, 4) && !$past(ps2_clk, 3)))
    else begin
      fail_cnt++;
      $error("receiver strobe not three cycles after a ps/2 clock fall");
    end

  // queue holds something after any push
  push_fills_queue: assert property (@(posedge clk) disable iff (!arst_n)
    push |=> !empty)
    else begin
      fail_cnt++;
      $error("queue still empty one cycle after a push");
    end

endmodule

bind ps2_lispm_kbd kbd_checker #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_checker (
  .clk         (clk),
  .arst_n      (arst_n),
  .ps2_clk     (ps2_clk),
  .rx_valid    (rx_valid),
  .frame_error (frame_error),
  .push        (push),
  .rd          (rd),
  .overflow    (overflow),
  .empty       (empty)
);

`default_nettype wire

// File: verification/tb_ps2_lispm_kbd.sv
//////////////////////////////
// testbench for the ps/2 to
// lisp machine keyboard path
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module tb_ps2_lispm_kbd import kbd_pkg::*; ();

  localparam int HALF = 8;
  // about 145 frames of 180 cycles, plus drains and margin
  localparam int CYCLE_LIMIT = 40000;
  localparam int NKEYS = 12;
  localparam raw_code_t KEY_RAW [NKEYS] = '{9'h01c, 9'h175, 9'h014, 9'h114, 9'h032, 9'h05a,
                                            9'h066, 9'h16b, 9'h045, 9'h012, 9'h111, 9'h00d};
  localparam lm_code_t  KEY_LM  [NKEYS] = '{8'o123, 8'o231, 8'o020, 8'o026, 8'o114, 8'o215,
                                            8'o207, 8'o233, 8'o171, 8'o024, 8'o165, 8'o211};

  logic       clk;
  logic       arst_n;
  logic       ps2_clk;
  logic       ps2_data;
  logic       rd;
  key_event_t key;
  logic       empty;
  logic       overflow;
  logic       frame_error;
  key_event_t exp_q [$];
  int         errors;
  int         cycle_cnt;
  int         ovf_cnt;
  int         fe_cnt;
  integer     seed;
  int         idx;

  ps2_lispm_kbd #(.IDLE_TIMEOUT(2000), .FIFO_DEPTH(8)) u_dut (
    .clk (clk), .arst_n (arst_n), .ps2_clk (ps2_clk), .ps2_data (ps2_data), .rd (rd),
    .key (key), .empty (empty), .overflow (overflow), .frame_error (frame_error)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (overflow) ovf_cnt++;
    if (frame_error) fe_cnt++;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // start, 8 data bits lsb first, odd parity, stop
  task automatic send_frame(input ps2_byte_t data, input bit bad_parity);
    logic [10:0] frame;
    int          i;
    frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    for (i = 0; i < 11; i++) begin
      ps2_data <= frame[i];
      repeat (HALF) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (HALF) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic send_key(input raw_code_t raw, input bit released);
    if (raw[8]) send_frame(PS2_PREFIX_EXT, 1'b0);
    if (released) send_frame(PS2_PREFIX_REL, 1'b0);
    send_frame(raw[7:0], 1'b0);
  endtask

  function automatic void expect_event(input lm_code_t code, input bit released);
    key_event_t ev;
    ev.released = released;
    ev.code     = code;
    exp_q.push_back(ev);
  endfunction

  task automatic check_count(input string test_name, input int expected, input int actual);
    assert (actual == expected) else begin
      errors++;
      $display("mismatch %s: expected %0d actual %0d", test_name, expected, actual);
    end
  endtask

  // pop every queued key and compare with the expected events
  task automatic drain_events(input string test_name);
    key_event_t exp;
    int         wait_cnt;
    while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      wait_cnt = 0;
      @(posedge clk);
      while (empty && wait_cnt < 400) begin
        @(posedge clk);
        wait_cnt++;
      end
      if (empty) begin
        errors++;
        $display("%s: expected key event %h never arrived", test_name, exp);
      end else begin
        assert (key == exp) else begin
          errors++;
          $display("mismatch %s: expected %h actual %h", test_name, exp, key);
        end
        rd <= 1'b1;
        @(posedge clk);
        rd <= 1'b0;
      end
    end
    repeat (20) @(posedge clk);
    check_count({test_name, " leftover"}, 1, int'(empty));
  endtask

  initial begin
    arst_n = 1'b0;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    rd = 1'b0;
    errors = 0;
    ovf_cnt = 0;
    fe_cnt = 0;
    seed = 32'h6096a1fc;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk);

    send_key(9'h01c, 1'b0);
    expect_event(8'o123, 1'b0);
    send_key(9'h01c, 1'b1);
    expect_event(8'o123, 1'b1);
    drain_events("make_break");

    send_key(9'h175, 1'b0);
    expect_event(8'o231, 1'b0);
    send_key(9'h175, 1'b1);
    expect_event(8'o231, 1'b1);
    send_key(9'h014, 1'b0);
    expect_event(8'o020, 1'b0);
    send_key(9'h114, 1'b0);
    expect_event(8'o026, 1'b0);
    drain_events("extended");

    send_key(9'h001, 1'b0);
    send_key(9'h001, 1'b1);
    repeat (20) @(posedge clk);
    check_count("unmapped empty", 1, int'(empty));
    send_key(9'h01c, 1'b0);
    expect_event(8'o123, 1'b0);
    drain_events("unmapped");

    send_frame(8'h1c, 1'b1);
    repeat (20) @(posedge clk);
    check_count("bad_parity frame_error", 1, fe_cnt);
    check_count("bad_parity empty", 1, int'(empty));
    send_key(9'h032, 1'b0);
    expect_event(8'o114, 1'b0);
    drain_events("bad_parity");

    // ten presses into an eight entry queue
    for (idx = 0; idx < 10; idx++) begin
      send_key(KEY_RAW[idx], 1'b0);
      if (idx < 8) expect_event(KEY_LM[idx], 1'b0);
    end
    repeat (20) @(posedge clk);
    check_count("overflow pulses", 2, ovf_cnt);
    drain_events("overflow");

    repeat (30) begin
      idx = $unsigned($random(seed)) % NKEYS;
      send_key(KEY_RAW[idx], 1'b0);
      expect_event(KEY_LM[idx], 1'b0);
      send_key(KEY_RAW[idx], 1'b1);
      expect_event(KEY_LM[idx], 1'b1);
      drain_events("random");
    end
    check_count("final frame_error", 1, fe_cnt);

    $display("errors: %0d testbench, %0d assertion", errors, u_dut.u_checker.fail_cnt);
    if (errors == 0 && u_dut.u_checker.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/kbd_pkg.sv
source/ps2_rx.sv
source/scancode_rom.sv
source/scancode_decoder.sv
source/key_fifo.sv
source/ps2_lispm_kbd.sv
verification/kbd_checker.sv
verification/tb_ps2_lispm_kbd.sv

// File: Bender.yml
package:
  name: ps2_lispm_kbd

sources:
  - source/kbd_pkg.sv
  - source/ps2_rx.sv
  - source/scancode_rom.sv
  - source/scancode_decoder.sv
  - source/key_fifo.sv
  - source/ps2_lispm_kbd.sv
  - target: test
    files:
      - verification/kbd_checker.sv
      - verification/tb_ps2_lispm_kbd.sv
